// ==== hw/dataMem_cfg.svh ====
`ifndef DATA_MEM_CFG_SVH
`define DATA_MEM_CFG_SVH

// data memory size in 32-bit words
`define MEM_WORDS 64

// byte address width, log2(MEM_WORDS * 4)
`define MEM_ADDR_W 8

// word index width, as carried on the bus
`define MEM_WORD_W (`MEM_ADDR_W - 2)

// every byte of the memory takes this value while rst is high
`define MEM_RESET_BYTE 8'h00

`endif

// ==== hw/mipsMemPkg.sv ====
package mipsMemPkg;

	typedef logic [31:0] mipsWord;
	typedef logic [7:0] mipsByte;

	typedef enum logic [3:0] {
		opNone,
		opLb,
		opLbu,
		opLh,
		opLhu,
		opLw,
		opSb,
		opSh,
		opSw
	} memOp;

	function automatic logic isStore(memOp op);
		return op inside {opSb, opSh, opSw};
	endfunction

	function automatic logic isSignedLoad(memOp op);
		return op inside {opLb, opLh};
	endfunction

	// bytes moved by the op, zero for opNone
	function automatic logic [2:0] accessBytes(memOp op);
		case (op)
			opLb, opLbu, opSb: return 3'd1;
			opLh, opLhu, opSh: return 3'd2;
			opLw, opSw: return 3'd4;
			default: return 3'd0;
		endcase
	endfunction

	// natural alignment: halfwords on even addresses, words on 4-byte boundaries
	function automatic logic isAligned(memOp op, logic [1:0] low);
		case (accessBytes(op))
			3'd2: return !low[0];
			3'd4: return low == 2'b00;
			default: return 1'b1;
		endcase
	endfunction

endpackage

// ==== hw/wbBusPkg.sv ====
package wbBusPkg;

	typedef logic [3:0] wbSel; // bit k enables byte lane k, little endian

	typedef enum logic [1:0] {
		lsIdle,
		lsBus,
		lsDone
	} lsuState;

	// select bits for an aligned access of the given size at the given lane
	function automatic wbSel laneSelect(logic [2:0] bytes, logic [1:0] lane);
		case (bytes)
			3'd1: return wbSel'(4'b0001 << lane);
			3'd2: return wbSel'(4'b0011 << lane);
			3'd4: return 4'b1111;
			default: return 4'b0000;
		endcase
	endfunction

endpackage

// ==== hw/loadStoreUnit.sv ====
`include "dataMem_cfg.svh"

module loadStoreUnit (
	input logic clock,
	input logic rst,

	input logic start,
	input mipsMemPkg::memOp op,
	input logic [`MEM_ADDR_W-1:0] addr,
	input mipsMemPkg::mipsWord storeData,
	output logic ready,
	output logic done,
	output mipsMemPkg::mipsWord loadData,
	output logic addrError,

	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output logic [`MEM_WORD_W-1:0] wbAdr,
	output wbBusPkg::wbSel wbSel,
	output mipsMemPkg::mipsWord wbDatW,
	input mipsMemPkg::mipsWord wbDatR,
	input logic wbAck
);

	import mipsMemPkg::*;
	import wbBusPkg::*;

	lsuState state;
	memOp opReg;         // op of the access in flight
	logic [1:0] laneReg; // low address bits of that access

	logic accept;
	logic [2:0] reqBytes;
	logic reqAligned;
	logic reqBus;
	logic [4:0] laneShift;

	mipsWord laneData;
	logic msb;
	logic extBit;
	mipsWord loadExt;

	assign ready = state == lsIdle;
	assign done = state == lsDone;
	assign accept = start && ready; // a start while busy is dropped

	// request decode, only used on the accepting edge
	always_comb begin
		reqBytes = accessBytes(op);
		reqAligned = isAligned(op, addr[1:0]);
		reqBus = reqAligned && (reqBytes != 3'd0);
		laneShift = {addr[1:0], 3'b000};
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= lsIdle;
			addrError <= 1'b0;
			wbCyc <= 1'b0;
			wbStb <= 1'b0;
		end else begin
			case (state)
				lsIdle: begin
					if (accept) begin
						addrError <= !reqAligned;
						if (reqBus) begin
							state <= lsBus;
							wbCyc <= 1'b1;
							wbStb <= 1'b1;
						end else begin
							state <= lsDone; // misaligned or opNone, no bus cycle
						end
					end
				end
				lsBus: begin
					if (wbAck) begin
						state <= lsDone;
						wbCyc <= 1'b0;
						wbStb <= 1'b0;
					end
				end
				lsDone: begin
					state <= lsIdle;
					addrError <= 1'b0;
				end
				default: state <= lsIdle;
			endcase
		end
	end

	// bus request fields and the result, loaded on accept and on ack
	always_ff @(posedge clock) begin
		if (accept) begin
			opReg <= op;
			laneReg <= addr[1:0];
			wbWe <= isStore(op);
			wbAdr <= addr[`MEM_ADDR_W-1:2];
			wbSel <= laneSelect(reqBytes, addr[1:0]);
			wbDatW <= storeData << laneShift;
			loadData <= '0; // stays zero for stores and errors
		end else if (state == lsBus && wbAck && !wbWe) begin
			loadData <= loadExt;
		end
	end

	// move the addressed lane down to bit 0 and extend it
	always_comb begin
		laneData = wbDatR >> {laneReg, 3'b000};
		case (accessBytes(opReg))
			3'd1: msb = laneData[7];
			3'd2: msb = laneData[15];
			default: msb = laneData[31];
		endcase
		extBit = isSignedLoad(opReg) && msb;
		case (opReg)
			opLb, opLbu: loadExt = {{24{extBit}}, laneData[7:0]};
			opLh, opLhu: loadExt = {{16{extBit}}, laneData[15:0]};
			opLw: loadExt = laneData;
			default: loadExt = '0;
		endcase
	end

endmodule

// ==== hw/byteLaneMemory.sv ====
`include "dataMem_cfg.svh"

module byteLaneMemory (
	input logic clock,
	input logic rst,

	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [`MEM_WORD_W-1:0] wbAdr,
	input wbBusPkg::wbSel wbSel,
	input mipsMemPkg::mipsWord wbDatW,
	output mipsMemPkg::mipsWord wbDatR,
	output logic wbAck
);

	import mipsMemPkg::*;

	// lane k holds the bytes whose address bits 1:0 equal k
	mipsByte memLanes [4][`MEM_WORDS];

	logic hit; // request seen and not yet acknowledged

	assign hit = wbCyc && wbStb && !wbAck;

	// one ack per cycle, a cycle after stb is first seen
	always_ff @(posedge clock) begin
		if (rst) begin
			wbAck <= 1'b0;
		end else begin
			wbAck <= hit;
		end
	end

	// writes land on the edge that raises ack
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int w = 0; w < `MEM_WORDS; w++) begin
				for (int k = 0; k < 4; k++) begin
					memLanes[k][w] <= `MEM_RESET_BYTE;
				end
			end
		end else if (hit && wbWe) begin
			for (int k = 0; k < 4; k++) begin
				if (wbSel[k]) begin
					memLanes[k][wbAdr] <= wbDatW[8*k +: 8];
				end
			end
		end
	end

	// whole word comes back with the ack, select bits don't matter here
	always_ff @(posedge clock) begin
		if (hit) begin
			for (int k = 0; k < 4; k++) begin
				wbDatR[8*k +: 8] <= memLanes[k][wbAdr];
			end
		end
	end

endmodule

// ==== hw/memoryStage.sv ====
`include "dataMem_cfg.svh"

module memoryStage (
	input logic clock,
	input logic rst,

	input logic start,
	input mipsMemPkg::memOp op,
	input logic [`MEM_ADDR_W-1:0] addr,
	input mipsMemPkg::mipsWord storeData,
	output logic ready,
	output logic done,
	output mipsMemPkg::mipsWord loadData,
	output logic addrError
);

	import mipsMemPkg::*;
	import wbBusPkg::*;

	// wishbone classic link, the load-store unit is the master
	logic cyc;
	logic stb;
	logic we;
	logic [`MEM_WORD_W-1:0] wordAdr;
	wbSel sel;
	mipsWord datW;
	mipsWord datR;
	logic ack;

	loadStoreUnit lsu (
		.clock(clock),
		.rst(rst),
		.start(start),
		.op(op),
		.addr(addr),
		.storeData(storeData),
		.ready(ready),
		.done(done),
		.loadData(loadData),
		.addrError(addrError),
		.wbCyc(cyc),
		.wbStb(stb),
		.wbWe(we),
		.wbAdr(wordAdr),
		.wbSel(sel),
		.wbDatW(datW),
		.wbDatR(datR),
		.wbAck(ack)
	);

	byteLaneMemory dataMem (
		.clock(clock),
		.rst(rst),
		.wbCyc(cyc),
		.wbStb(stb),
		.wbWe(we),
		.wbAdr(wordAdr),
		.wbSel(sel),
		.wbDatW(datW),
		.wbDatR(datR),
		.wbAck(ack)
	);

endmodule

// ==== tests/memoryStageTb.sv ====
`include "dataMem_cfg.svh"

module memoryStageTb;

	import mipsMemPkg::*;

	localparam int MemBytes = `MEM_WORDS * 4;
	localparam int WaitLimit = 20;

	logic clock;
	logic rst;
	logic start;
	memOp op;
	logic [`MEM_ADDR_W-1:0] addr;
	mipsWord storeData;
	logic ready;
	logic done;
	mipsWord loadData;
	logic addrError;

	mipsByte model [MemBytes]; // one entry per byte address
	integer seed;

	memoryStage uut (
		.clock(clock),
		.rst(rst),
		.start(start),
		.op(op),
		.addr(addr),
		.storeData(storeData),
		.ready(ready),
		.done(done),
		.loadData(loadData),
		.addrError(addrError)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic mipsWord randomWord();
		return $random(seed);
	endfunction

	function automatic int opBytes(memOp o);
		case (o)
			opLb, opLbu, opSb: return 1;
			opLh, opLhu, opSh: return 2;
			opLw, opSw: return 4;
			default: return 0;
		endcase
	endfunction

	function automatic bit writesMemory(memOp o);
		return o == opSb || o == opSh || o == opSw;
	endfunction

	function automatic bit misaligned(memOp o, logic [1:0] low);
		return (opBytes(o) == 2 && low[0]) || (opBytes(o) == 4 && low != 2'b00);
	endfunction

	// bytes in address order with the lowest address in bits 7:0
	function automatic mipsWord expectedLoad(memOp o, logic [`MEM_ADDR_W-1:0] a);
		mipsWord w;
		logic [`MEM_ADDR_W-1:0] ba;
		w = '0;
		ba = a;
		for (int i = 0; i < opBytes(o); i++) begin
			w = w | (mipsWord'(model[ba]) << (8 * i));
			ba = ba + 1'b1;
		end
		if (o == opLb) w = {{24{w[7]}}, w[7:0]};
		if (o == opLh) w = {{16{w[15]}}, w[15:0]};
		return w;
	endfunction

	task automatic storeModel(input memOp o, input logic [`MEM_ADDR_W-1:0] a, input mipsWord d);
		logic [`MEM_ADDR_W-1:0] ba;
		mipsWord rest;
		ba = a;
		rest = d;
		for (int i = 0; i < opBytes(o); i++) begin
			model[ba] = rest[7:0];
			rest = rest >> 8;
			ba = ba + 1'b1;
		end
	endtask

	// mostly the low 16 bytes so loads see earlier stores
	function automatic logic [`MEM_ADDR_W-1:0] pickAddr(int n, bit forceAlign);
		mipsWord r;
		logic [`MEM_ADDR_W-1:0] a;
		r = randomWord();
		a = r[`MEM_ADDR_W-1:0];
		if (r[10:8] != 3'd0) a[`MEM_ADDR_W-1:4] = '0;
		if (forceAlign || r[15:12] != 4'd0) begin
			if (n == 2) a[0] = 1'b0;
			if (n == 4) a[1:0] = 2'b00;
		end
		return a;
	endfunction

	function automatic memOp pickOp(logic [3:0] k);
		case (k)
			4'd0: return opNone;
			4'd1: return opLb;
			4'd2: return opLbu;
			4'd3: return opLh;
			4'd4: return opLhu;
			4'd5, 4'd6: return opLw;
			4'd7, 4'd8: return opSb;
			4'd9, 4'd10: return opSh;
			default: return opSw;
		endcase
	endfunction

	task automatic compare(input logic [31:0] got, input logic [31:0] want, input string what);
		if (got !== want) begin
			$display("Fail %0t: %s, got %h expected %h", $time, what, got, want);
			$display("Finished with errors");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic timeoutStop(input string what);
		$display("Timeout at %0t: no %s within %0d cycles", $time, what, WaitLimit);
		$display("Finished with errors");
		$fatal(1, "stopped on timeout");
	endtask

	// one operation; hold keeps start high with junk until done has cleared
	task automatic runOp(input memOp o, input logic [`MEM_ADDR_W-1:0] a, input mipsWord d,
			input bit hold);
		int cycles;
		int latency;
		bit bad;
		mipsWord want;
		cycles = 0;
		while (!ready && cycles < WaitLimit) begin
			@(posedge clock);
			#1;
			cycles++;
		end
		if (!ready) timeoutStop("ready");
		bad = misaligned(o, a[1:0]);
		latency = (bad || o == opNone) ? 1 : 3;
		want = '0;
		if (!bad && opBytes(o) != 0 && !writesMemory(o)) want = expectedLoad(o, a);
		start = 1'b1;
		op = o;
		addr = a;
		storeData = d;
		cycles = 0;
		do begin
			@(posedge clock);
			#1;
			cycles++;
			if (hold) begin
				op = opSw; // would corrupt memory if it were taken
				addr = pickAddr(4, 1'b1);
				storeData = randomWord();
			end else begin
				start = 1'b0;
			end
		end while (!done && cycles < WaitLimit);
		if (!done) timeoutStop("done");
		compare(cycles, latency, "done latency");
		compare(32'(addrError), 32'(bad), "addrError");
		compare(loadData, want, "loadData");
		if (!bad && writesMemory(o)) storeModel(o, a, d);
		@(posedge clock);
		#1;
		start = 1'b0; // a held start stays up through the done cycle
		compare(32'(done), 32'd0, "done after pulse");
		compare(32'(ready), 32'd1, "ready after done");
	endtask

	initial begin
		logic [`MEM_ADDR_W-1:0] a;
		mipsWord r;
		seed = 62;
		rst = 1'b1;
		start = 1'b0;
		op = opNone;
		addr = '0;
		storeData = '0;
		model = '{default: `MEM_RESET_BYTE};
		repeat (5) @(posedge clock);
		#1;
		rst = 1'b0;
		compare(32'(ready), 32'd1, "ready after reset");
		compare(32'(done), 32'd0, "done after reset");
		repeat (4) runOp(opLw, pickAddr(4, 1'b1), '0, 1'b0);

		repeat (8) begin
			a = pickAddr(4, 1'b1);
			runOp(opSw, a, randomWord(), 1'b0);
			runOp(opLw, a, '0, 1'b0);
		end

		// partial stores then the whole word
		repeat (8) begin
			a = pickAddr(1, 1'b1);
			runOp(opSb, a, randomWord(), 1'b0);
			runOp(opLw, {a[`MEM_ADDR_W-1:2], 2'b00}, '0, 1'b0);
			a = pickAddr(2, 1'b1);
			runOp(opSh, a, randomWord(), 1'b0);
			runOp(opLw, {a[`MEM_ADDR_W-1:2], 2'b00}, '0, 1'b0);
		end

		repeat (6) begin
			a = pickAddr(4, 1'b1);
			runOp(opSw, a, randomWord(), 1'b0);
			for (int k = 0; k < 4; k++) begin
				runOp(opLb, a + k[`MEM_ADDR_W-1:0], '0, 1'b0);
				runOp(opLbu, a + k[`MEM_ADDR_W-1:0], '0, 1'b0);
			end
			runOp(opLh, a, '0, 1'b0);
			runOp(opLhu, a + 2'd2, '0, 1'b0);
			runOp(opLh, a + 2'd2, '0, 1'b0);
			runOp(opLhu, a, '0, 1'b0);
		end

		// misaligned accesses then loads that show the stores went nowhere
		a = pickAddr(4, 1'b1);
		runOp(opLh, a + 1'b1, '0, 1'b0);
		runOp(opSh, a + 2'd3, randomWord(), 1'b0);
		runOp(opLw, a + 2'd2, '0, 1'b0);
		runOp(opSw, a + 1'b1, randomWord(), 1'b0);
		runOp(opSw, a + 2'd2, randomWord(), 1'b0);
		runOp(opNone, a, randomWord(), 1'b0);
		runOp(opLw, a, '0, 1'b0);
		runOp(opLw, a + 3'd4, '0, 1'b0);

		runOp(opSw, pickAddr(4, 1'b1), randomWord(), 1'b1);
		runOp(opLw, pickAddr(4, 1'b1), '0, 1'b1);
		runOp(opSh, a + 1'b1, randomWord(), 1'b1);
		runOp(opNone, a, '0, 1'b1);

		repeat (400) begin
			r = randomWord();
			op = pickOp(r[3:0]);
			runOp(op, pickAddr(opBytes(op), 1'b0), randomWord(), r[20:16] == 5'd0);
		end

		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/mipsMemPkg.sv
hw/wbBusPkg.sv
hw/loadStoreUnit.sv
hw/byteLaneMemory.sv
hw/memoryStage.sv
tests/memoryStageTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --timing -f verilog.f --top-module memoryStageTb -o memoryStageSim &&
	./obj_dir/memoryStageSim 2>&1)
echo "$out"
echo "$out" | grep -q "Finished with no errors" && echo "PASS" || { echo "FAIL"; exit 1; }
